/* common/i2c_pkg.sv */
// I2C master shared definitions
package i2c_pkg;

    //******************************
    // bus data types
    //******************************
    typedef logic [7:0]  byte_t;        // data or address byte on the bus
    typedef logic [6:0]  dev_addr_t;    // 7-bit device address
    typedef logic [15:0] word_addr_t;   // register address inside the device

    //******************************
    // bus timing
    //******************************
    localparam int PHASES     = 4;      // dri_clk cycles per bit slot
    localparam int BYTE_SLOTS = 9;      // 8 data bits + ack

    // one frame on the bus, issued by the control fsm
    typedef enum logic [2:0] {
        fr_start   = 3'd0,
        fr_restart = 3'd1,
        fr_tx_byte = 3'd2,
        fr_rx_ack  = 3'd3,              // receive, master acks
        fr_rx_nack = 3'd4,              // receive, last byte
        fr_stop    = 3'd5
    } frame_op_e;

    // transaction sequence
    typedef enum logic [3:0] {
        st_idle    = 4'd0,
        st_start   = 4'd1,
        st_dev_wr  = 4'd2,              // device address, R/W = 0
        st_addr_hi = 4'd3,              // only with addr_16
        st_addr_lo = 4'd4,
        st_restart = 4'd5,
        st_dev_rd  = 4'd6,              // device address, R/W = 1
        st_write   = 4'd7,
        st_read    = 4'd8,
        st_stop    = 4'd9
    } ctrl_state_e;

endpackage

/* i2c_master/i2c_bit_timer.sv */
// I2C bit slot timer
`timescale 1ns/100ps

module i2c_bit_timer (
    input  logic               dri_clk,
    input  logic               rst_n,
    input  logic               frame_go,
    input  i2c_pkg::frame_op_e frame_op,
    output logic [1:0]         phase,
    output logic [3:0]         slot,
    output logic               frame_end
);

    logic       busy;
    logic [3:0] last_slot;
    logic       byte_op;

    assign byte_op = frame_op inside {i2c_pkg::fr_tx_byte, i2c_pkg::fr_rx_ack,
                                      i2c_pkg::fr_rx_nack};

    assign frame_end = busy && (phase == 2'(i2c_pkg::PHASES - 1)) && (slot == last_slot);

    // frame_go cycle is phase 0 of slot 0
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            phase     <= '0;
            slot      <= '0;
            last_slot <= '0;
        end else if (frame_go) begin
            busy      <= 1'b1;
            phase     <= 2'd1;
            slot      <= '0;
            last_slot <= byte_op ? 4'(i2c_pkg::BYTE_SLOTS - 1) : 4'd0;
        end else if (frame_end) begin
            busy  <= 1'b0;
            phase <= '0;                            // hold at zero when idle
            slot  <= '0;
        end else if (busy) begin
            phase <= phase + 2'd1;
            if (phase == 2'(i2c_pkg::PHASES - 1))
                slot <= slot + 4'd1;
        end
    end

endmodule

/* i2c_master/i2c_bit_engine.sv */
// I2C bit engine and line driver
`timescale 1ns/100ps

module i2c_bit_engine (
    input  logic               dri_clk,
    input  logic               rst_n,
    input  logic               frame_go,
    input  i2c_pkg::frame_op_e frame_op,
    input  i2c_pkg::byte_t     tx_byte,
    input  logic [1:0]         phase,
    input  logic [3:0]         slot,
    input  logic               frame_end,
    input  logic               sda_in,
    output logic               scl,
    output logic               sda_low,
    output i2c_pkg::byte_t     rx_byte,
    output logic               ack_nak
);

    i2c_pkg::frame_op_e op_q;
    i2c_pkg::frame_op_e op;
    i2c_pkg::byte_t     tx_sr;
    logic               busy;
    logic               active;
    logic               tx_bit;
    logic               ack_slot;
    logic               is_cond;
    logic               is_rx;

    assign active   = busy | frame_go;
    assign op       = frame_go ? frame_op : op_q;
    assign tx_bit   = frame_go ? tx_byte[7] : tx_sr[7];
    assign ack_slot = (slot == 4'(i2c_pkg::BYTE_SLOTS - 1));
    assign is_rx    = (op == i2c_pkg::fr_rx_ack) || (op == i2c_pkg::fr_rx_nack);
    assign is_cond  = op inside {i2c_pkg::fr_start, i2c_pkg::fr_restart, i2c_pkg::fr_stop};

    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            op_q <= i2c_pkg::fr_stop;
        end else if (frame_go) begin
            busy <= 1'b1;
            op_q <= frame_op;
        end else if (frame_end) begin
            busy <= 1'b0;
        end
    end

    //******************************
    // scl / sda sequencing per slot
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            scl     <= 1'b1;                        // bus released
            sda_low <= 1'b0;
            ack_nak <= 1'b0;
        end else if (active) begin
            case (phase)
                2'd0: begin
                    scl <= (op == i2c_pkg::fr_start);   // start comes from idle, scl high
                    case (op)
                        i2c_pkg::fr_start,
                        i2c_pkg::fr_restart: sda_low <= 1'b0;
                        i2c_pkg::fr_stop:    sda_low <= 1'b1;
                        i2c_pkg::fr_tx_byte: sda_low <= ack_slot ? 1'b0 : ~tx_bit;
                        default:             sda_low <= ack_slot && (op == i2c_pkg::fr_rx_ack);
                    endcase
                end
                2'd1: scl <= 1'b1;
                2'd2: begin
                    if (is_cond)
                        sda_low <= (op != i2c_pkg::fr_stop);  // edge while scl high
                    else if (ack_slot)
                        ack_nak <= sda_in;
                end
                default: begin
                    if (op != i2c_pkg::fr_stop)
                        scl <= 1'b0;
                end
            endcase
        end
    end

    // data shifting, msb first
    always_ff @(posedge dri_clk) begin
        if (frame_go)
            tx_sr <= tx_byte;
        else if (busy && phase == 2'd3)
            tx_sr <= {tx_sr[6:0], 1'b0};
        if (busy && phase == 2'd2 && is_rx && !ack_slot)
            rx_byte <= {rx_byte[6:0], sda_in};
    end

endmodule

/* i2c_master/i2c_ctrl_fsm.sv */
// I2C transaction sequencer
`timescale 1ns/100ps

module i2c_ctrl_fsm #(
    parameter int BURST_W = 4
) (
    input  logic                    dri_clk,
    input  logic                    rst_n,
    input  logic                    exec,
    input  logic                    rd,
    input  i2c_pkg::dev_addr_t      slave_addr,
    input  i2c_pkg::word_addr_t     word_addr,
    input  logic                    addr_16,
    input  logic [BURST_W-1:0]      burst_len,
    input  i2c_pkg::byte_t          wr_data,
    input  logic                    frame_end,
    input  logic                    ack_nak,
    input  i2c_pkg::byte_t          rx_byte,
    output logic                    frame_go,
    output i2c_pkg::frame_op_e      frame_op,
    output i2c_pkg::byte_t          tx_byte,
    output i2c_pkg::byte_t          rd_data,
    output logic                    byte_done,
    output logic                    done,
    output logic                    nak
);

    i2c_pkg::ctrl_state_e state;
    i2c_pkg::dev_addr_t   dev_q;
    i2c_pkg::word_addr_t  addr_q;
    logic                 rd_q;
    logic                 a16_q;
    logic [BURST_W-1:0]   len_q;
    logic [BURST_W-1:0]   cnt;                  // data bytes finished
    logic                 last_byte;
    logic                 start_req;

    assign start_req = exec && (state == i2c_pkg::st_idle);
    assign last_byte = (cnt == len_q - BURST_W'(1));

    //******************************
    // request capture
    //******************************
    always_ff @(posedge dri_clk) begin
        if (start_req) begin
            dev_q  <= slave_addr;
            addr_q <= word_addr;
            rd_q   <= rd;
            a16_q  <= addr_16;
            len_q  <= burst_len;
        end
        if (frame_end && state == i2c_pkg::st_read)
            rd_data <= rx_byte;
    end

    //******************************
    // frame sequencing
    //******************************
    always_ff @(posedge dri_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= i2c_pkg::st_idle;
            frame_go  <= 1'b0;
            byte_done <= 1'b0;
            done      <= 1'b0;
            nak       <= 1'b0;
            cnt       <= '0;
        end else begin
            frame_go  <= 1'b0;
            byte_done <= 1'b0;
            done      <= 1'b0;
            if (start_req) begin
                state    <= i2c_pkg::st_start;
                frame_go <= 1'b1;
                nak      <= 1'b0;
                cnt      <= '0;
            end else if (frame_end) begin
                frame_go <= 1'b1;                   // next frame right after this one
                case (state)
                    i2c_pkg::st_start: state <= i2c_pkg::st_dev_wr;
                    i2c_pkg::st_dev_wr: begin
                        if (ack_nak) begin
                            nak   <= 1'b1;
                            state <= i2c_pkg::st_stop;
                        end else begin
                            state <= a16_q ? i2c_pkg::st_addr_hi : i2c_pkg::st_addr_lo;
                        end
                    end
                    i2c_pkg::st_addr_hi: begin
                        nak   <= ack_nak;
                        state <= ack_nak ? i2c_pkg::st_stop : i2c_pkg::st_addr_lo;
                    end
                    i2c_pkg::st_addr_lo: begin
                        if (ack_nak) begin
                            nak   <= 1'b1;
                            state <= i2c_pkg::st_stop;
                        end else begin
                            state <= rd_q ? i2c_pkg::st_restart : i2c_pkg::st_write;
                        end
                    end
                    i2c_pkg::st_restart: state <= i2c_pkg::st_dev_rd;
                    i2c_pkg::st_dev_rd: begin
                        nak   <= ack_nak;
                        state <= ack_nak ? i2c_pkg::st_stop : i2c_pkg::st_read;
                    end
                    i2c_pkg::st_write: begin
                        if (ack_nak) begin
                            nak   <= 1'b1;              // abort, byte not counted
                            state <= i2c_pkg::st_stop;
                        end else begin
                            byte_done <= 1'b1;
                            cnt       <= cnt + BURST_W'(1);
                            if (last_byte)
                                state <= i2c_pkg::st_stop;
                        end
                    end
                    i2c_pkg::st_read: begin
                        byte_done <= 1'b1;
                        cnt       <= cnt + BURST_W'(1);
                        if (last_byte)
                            state <= i2c_pkg::st_stop;
                    end
                    i2c_pkg::st_stop: begin
                        frame_go <= 1'b0;
                        done     <= 1'b1;
                        state    <= i2c_pkg::st_idle;
                    end
                    default: begin
                        frame_go <= 1'b0;
                        state    <= i2c_pkg::st_idle;
                    end
                endcase
            end
        end
    end

    // op and byte decode from state, taken by the bit blocks on frame_go
    always_comb begin
        case (state)
            i2c_pkg::st_start:   frame_op = i2c_pkg::fr_start;
            i2c_pkg::st_restart: frame_op = i2c_pkg::fr_restart;
            i2c_pkg::st_stop:    frame_op = i2c_pkg::fr_stop;
            i2c_pkg::st_read:    frame_op = last_byte ? i2c_pkg::fr_rx_nack : i2c_pkg::fr_rx_ack;
            default:             frame_op = i2c_pkg::fr_tx_byte;
        endcase
    end

    // wr_data is taken in the frame_go cycle, which is also the byte_done of the byte before
    always_comb begin
        case (state)
            i2c_pkg::st_dev_wr:  tx_byte = {dev_q, 1'b0};
            i2c_pkg::st_dev_rd:  tx_byte = {dev_q, 1'b1};
            i2c_pkg::st_addr_hi: tx_byte = addr_q[15:8];
            i2c_pkg::st_addr_lo: tx_byte = addr_q[7:0];
            i2c_pkg::st_write:   tx_byte = wr_data;
            default:             tx_byte = '0;
        endcase
    end

endmodule

/* hdl/i2c_master_top.sv */
// I2C burst master top level
`timescale 1ns/100ps

module i2c_master_top #(
    parameter int BURST_W = 4
) (
    input  logic                dri_clk,
    input  logic                rst_n,
    input  logic                exec,
    input  logic                rd,
    input  i2c_pkg::dev_addr_t  slave_addr,
    input  i2c_pkg::word_addr_t word_addr,
    input  logic                addr_16,
    input  logic [BURST_W-1:0]  burst_len,
    input  i2c_pkg::byte_t      wr_data,
    input  logic                sda_in,
    output i2c_pkg::byte_t      rd_data,
    output logic                byte_done,
    output logic                done,
    output logic                nak,
    output logic                scl,
    output logic                sda_low
);

    logic               frame_go;
    logic               frame_end;
    logic               ack_nak;
    logic [1:0]         phase;
    logic [3:0]         slot;
    i2c_pkg::frame_op_e frame_op;
    i2c_pkg::byte_t     tx_byte;
    i2c_pkg::byte_t     rx_byte;

    i2c_ctrl_fsm #(
        .BURST_W    (BURST_W)
    ) u_ctrl (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .exec       (exec),
        .rd         (rd),
        .slave_addr (slave_addr),
        .word_addr  (word_addr),
        .addr_16    (addr_16),
        .burst_len  (burst_len),
        .wr_data    (wr_data),
        .frame_end  (frame_end),
        .ack_nak    (ack_nak),
        .rx_byte    (rx_byte),
        .frame_go   (frame_go),
        .frame_op   (frame_op),
        .tx_byte    (tx_byte),
        .rd_data    (rd_data),
        .byte_done  (byte_done),
        .done       (done),
        .nak        (nak)
    );

    i2c_bit_timer u_timer (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .frame_go   (frame_go),
        .frame_op   (frame_op),
        .phase      (phase),
        .slot       (slot),
        .frame_end  (frame_end)
    );

    i2c_bit_engine u_engine (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .frame_go   (frame_go),
        .frame_op   (frame_op),
        .tx_byte    (tx_byte),
        .phase      (phase),
        .slot       (slot),
        .frame_end  (frame_end),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_low    (sda_low),
        .rx_byte    (rx_byte),
        .ack_nak    (ack_nak)
    );

endmodule

/* test/i2c_slave_model.sv */
// Behavioral I2C memory slave
`timescale 1ns/100ps

module i2c_slave_model #(
    parameter logic [6:0] SLV_ADDR = 7'h50
) (
    input  logic scl,
    input  logic sda,
    input  logic addr_16,
    output logic sda_low
);

    localparam int S_IDLE  = 0;
    localparam int S_DEV   = 1;
    localparam int S_AHI   = 2;
    localparam int S_ALO   = 3;
    localparam int S_WDATA = 4;
    localparam int S_RDATA = 5;

    logic [7:0]  mem [logic [15:0]];        // sparse memory
    logic [15:0] ptr        = '0;
    logic [7:0]  shift      = '0;
    logic [7:0]  out_byte   = '0;
    int          state      = S_IDLE;
    int          bit_cnt    = 0;
    logic        in_ack     = 1'b0;         // inside the ninth slot
    logic        master_ack = 1'b0;
    logic        drive_low  = 1'b0;
    logic        scl_q      = 1'b1;
    logic        sda_q      = 1'b1;

    assign sda_low = drive_low;

    function automatic logic [7:0] mem_read(input logic [15:0] a);
        return mem.exists(a) ? mem[a] : 8'hff;
    endfunction

    always @(scl or sda) begin
        if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b1 && sda === 1'b0) begin
            state     = S_DEV;                  // start or repeated start
            bit_cnt   = 0;
            in_ack    = 1'b0;
            drive_low = 1'b0;
        end else if (scl_q === 1'b1 && scl === 1'b1 && sda_q === 1'b0 && sda === 1'b1) begin
            state     = S_IDLE;                 // stop
            bit_cnt   = 0;
            in_ack    = 1'b0;
            drive_low = 1'b0;
        end else if (scl_q === 1'b0 && scl === 1'b1 && state != S_IDLE) begin
            if (in_ack) begin
                if (state == S_RDATA)
                    master_ack = (sda === 1'b0);
            end else if (bit_cnt < 8) begin
                shift   = {shift[6:0], sda};
                bit_cnt = bit_cnt + 1;
            end
        end else if (scl_q === 1'b1 && scl === 1'b0 && state != S_IDLE) begin
            if (in_ack) begin
                in_ack    = 1'b0;
                bit_cnt   = 0;
                drive_low = 1'b0;
                if (state == S_RDATA) begin
                    if (master_ack) begin
                        out_byte  = mem_read(ptr);
                        ptr       = ptr + 16'd1;
                        drive_low = ~out_byte[7];
                    end else begin
                        state = S_IDLE;         // master nack, wait for stop
                    end
                end
            end else if (bit_cnt == 8) begin
                in_ack = 1'b1;
                case (state)
                    S_DEV: begin
                        if (shift[7:1] == SLV_ADDR) begin
                            drive_low = 1'b1;
                            if (shift[0])
                                state = S_RDATA;
                            else
                                state = addr_16 ? S_AHI : S_ALO;
                        end else begin
                            state = S_IDLE;     // not ours, no ack
                        end
                    end
                    S_AHI: begin
                        ptr[15:8] = shift;
                        drive_low = 1'b1;
                        state     = S_ALO;
                    end
                    S_ALO: begin
                        ptr[7:0] = shift;
                        if (!addr_16)
                            ptr[15:8] = 8'h00;
                        drive_low = 1'b1;
                        state     = S_WDATA;
                    end
                    S_WDATA: begin
                        mem[ptr]  = shift;
                        ptr       = ptr + 16'd1;
                        drive_low = 1'b1;
                    end
                    default: drive_low = 1'b0;  // master answers the read byte
                endcase
            end else if (state == S_RDATA) begin
                drive_low = ~out_byte[7 - bit_cnt];
            end
        end
        scl_q = scl;
        sda_q = sda;
    end

endmodule

/* test/tb_i2c_master.sv */
// I2C master testbench
`timescale 1ns/100ps

module tb_i2c_master;

    localparam int BURST_W    = 4;
    localparam int MAX_BYTES  = 8;
    localparam int XFER_LIMIT = 2000;           // dri_clk cycles per transfer

    logic                dri_clk;
    logic                rst_n;
    logic                exec;
    logic                rd;
    i2c_pkg::dev_addr_t  slave_addr;
    i2c_pkg::word_addr_t word_addr;
    logic                addr_16;
    logic [BURST_W-1:0]  burst_len;
    i2c_pkg::byte_t      wr_data;
    i2c_pkg::byte_t      rd_data;
    logic                byte_done;
    logic                done;
    logic                nak;
    logic                scl;
    logic                sda_low;
    logic                slv_sda_low;
    logic                sda_line;

    i2c_pkg::byte_t mirror [logic [15:0]];      // expected memory contents
    i2c_pkg::byte_t wbytes [MAX_BYTES];
    int             errors     = 0;
    int             timeouts   = 0;
    int             accepted   = 0;
    int             done_total = 0;

    assign sda_line = ~(sda_low | slv_sda_low); // wired-and with pull-up

    i2c_master_top #(
        .BURST_W    (BURST_W)
    ) i_dut (
        .dri_clk    (dri_clk),
        .rst_n      (rst_n),
        .exec       (exec),
        .rd         (rd),
        .slave_addr (slave_addr),
        .word_addr  (word_addr),
        .addr_16    (addr_16),
        .burst_len  (burst_len),
        .wr_data    (wr_data),
        .sda_in     (sda_line),
        .rd_data    (rd_data),
        .byte_done  (byte_done),
        .done       (done),
        .nak        (nak),
        .scl        (scl),
        .sda_low    (sda_low)
    );

    i2c_slave_model #(
        .SLV_ADDR   (7'h50)
    ) i_slave (
        .scl        (scl),
        .sda        (sda_line),
        .addr_16    (addr_16),
        .sda_low    (slv_sda_low)
    );

    initial begin
        dri_clk = 1'b0;
        forever #4 dri_clk = ~dri_clk;
    end

    always @(posedge dri_clk) begin
        if (done)
            done_total <= done_total + 1;
    end

    //******************************
    // compare tasks
    //******************************
    task automatic check_byte(input string tname, input i2c_pkg::byte_t exp,
                              input i2c_pkg::byte_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_flag(input string tname, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %b, actual %b", tname, exp, act);
        end
    endtask

    task automatic check_count(input string tname, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", tname, exp, act);
        end
    endtask

    //******************************
    // one transfer
    //******************************
    task automatic run_transfer(input string tname, input logic op_rd,
                                input i2c_pkg::dev_addr_t dev, input logic a16,
                                input i2c_pkg::word_addr_t addr, input int len,
                                input logic exp_nak, input logic busy_exec,
                                output logic timed_out);
        logic [15:0] ptr;
        logic [15:0] a_cur;
        int          cycles;
        int          n_bd;
        logic        seen_done;
        ptr       = a16 ? addr : {8'h00, addr[7:0]};
        cycles    = 0;
        n_bd      = 0;
        seen_done = 1'b0;
        timed_out = 1'b0;
        rd         = op_rd;
        slave_addr = dev;
        word_addr  = addr;
        addr_16    = a16;
        burst_len  = BURST_W'(len);
        wr_data    = wbytes[0];
        exec       = 1'b1;
        @(posedge dri_clk);
        #1;
        exec = 1'b0;
        accepted++;
        while (!seen_done && cycles < XFER_LIMIT) begin
            @(posedge dri_clk);
            #1;
            cycles++;
            if (busy_exec && cycles == 50) begin
                exec       = 1'b1;              // must be ignored
                slave_addr = ~dev;
                word_addr  = ~addr;
            end else if (busy_exec && cycles == 51) begin
                exec       = 1'b0;
                slave_addr = dev;
                word_addr  = addr;
            end
            if (byte_done) begin
                if (op_rd) begin
                    a_cur = ptr + 16'(n_bd);
                    if (!mirror.exists(a_cur)) begin
                        errors++;
                        $display("%s reads address %h that no earlier test wrote",
                                 tname, a_cur);
                    end else begin
                        check_byte(tname, mirror[a_cur], rd_data);
                    end
                end else if (n_bd + 1 < MAX_BYTES) begin
                    wr_data = wbytes[n_bd + 1]; // taken in this same cycle
                end
                n_bd++;
            end
            if (done)
                seen_done = 1'b1;
        end
        if (!seen_done) begin
            timeouts++;
            $display("timeout waiting for done");
            timed_out = 1'b1;
            return;
        end
        check_flag({tname, " nak"}, exp_nak, nak);
        check_count({tname, " byte_done"}, exp_nak ? 0 : len, n_bd);
        if (!op_rd && !exp_nak) begin
            for (int i = 0; i < len; i++)
                mirror[ptr + 16'(i)] = wbytes[i];
        end
        repeat (20) @(posedge dri_clk);
        #1;
        check_flag({tname, " scl idle"}, 1'b1, scl);
    endtask

    //******************************
    // stimulus
    //******************************
    initial begin
        int             fd;
        int             n;
        string          line;
        string          tname;
        logic [8*24-1:0] name_r;
        int             f_rd;
        logic [7:0]     f_dev;
        int             f_a16;
        logic [15:0]    f_addr;
        int             f_len;
        int             f_nak;
        int             f_busy;
        logic [7:0]     b0, b1, b2, b3, b4, b5, b6, b7;
        logic           timed_out;
        logic           aborted;
        rst_n      = 1'b0;
        exec       = 1'b0;
        rd         = 1'b0;
        slave_addr = '0;
        word_addr  = '0;
        addr_16    = 1'b0;
        burst_len  = '0;
        wr_data    = '0;
        aborted    = 1'b0;
        timed_out  = 1'b0;
        repeat (5) @(posedge dri_clk);
        #1;
        check_flag("reset scl", 1'b1, scl);
        check_flag("reset sda_low", 1'b0, sda_low);
        check_flag("reset done", 1'b0, done);
        check_flag("reset byte_done", 1'b0, byte_done);
        check_flag("reset nak", 1'b0, nak);
        rst_n = 1'b1;
        @(posedge dri_clk);
        #1;

        fd = $fopen("test/i2c_tests.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open the test list test/i2c_tests.txt");
        end else begin
            while (!aborted && !$feof(fd)) begin
                n = $fgets(line, fd);
                if (n > 2 && line.getc(0) != 8'h23) begin   // skip '#' lines
                    n = $sscanf(line, "%s %d %h %d %h %d %d %d %h %h %h %h %h %h %h %h",
                                name_r, f_rd, f_dev, f_a16, f_addr, f_len, f_nak, f_busy,
                                b0, b1, b2, b3, b4, b5, b6, b7);
                    if (n != 16) begin
                        errors++;
                        $display("bad line in test list: %s", line);
                    end else begin
                        tname = $sformatf("%0s", name_r);
                        wbytes = '{b0, b1, b2, b3, b4, b5, b6, b7};
                        run_transfer(tname, f_rd != 0, f_dev[6:0], f_a16 != 0, f_addr,
                                     f_len, f_nak != 0, f_busy != 0, timed_out);
                        aborted = timed_out;
                    end
                end
            end
            $fclose(fd);
        end

        repeat (30) @(posedge dri_clk);
        #1;
        if (!aborted)
            check_count("done pulses", accepted, done_total);
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* test/i2c_tests.txt */
# name rd dev a16 addr len nak busy b0 b1 b2 b3 b4 b5 b6 b7
# rd 1 = read, busy 1 = extra exec while busy, bytes feed writes only
wr_single     0 50 0 0034 1 0 0 a5 00 00 00 00 00 00 00
rd_single     1 50 0 0034 1 0 0 00 00 00 00 00 00 00 00
wr_burst16    0 50 1 1200 6 0 0 11 22 33 44 55 66 00 00
rd_burst16    1 50 1 1200 6 0 0 00 00 00 00 00 00 00 00
rd_mid16      1 50 1 1202 3 0 0 00 00 00 00 00 00 00 00
wr_burst8     0 50 0 0080 8 0 0 de ad be ef 01 23 45 67
rd_mid8       1 50 0 0083 4 0 0 00 00 00 00 00 00 00 00
wr_mask       0 50 0 7790 2 0 0 3c c3 00 00 00 00 00 00
rd_mask       1 50 1 0090 2 0 0 00 00 00 00 00 00 00 00
wr_bad_dev    0 51 0 0010 2 1 0 aa bb 00 00 00 00 00 00
rd_after_bad  1 50 0 0034 1 0 0 00 00 00 00 00 00 00 00
rd_bad_dev    1 23 1 1200 2 1 0 00 00 00 00 00 00 00 00
wr_after_bad  0 50 1 1206 2 0 0 77 88 00 00 00 00 00 00
rd_join       1 50 1 1204 4 0 0 00 00 00 00 00 00 00 00
wr_busy       0 50 0 0040 3 0 1 c1 c2 c3 00 00 00 00 00
rd_busy_check 1 50 0 0040 3 0 0 00 00 00 00 00 00 00 00
rd_busy       1 50 1 1200 8 0 1 00 00 00 00 00 00 00 00

/* vlog.f */
common/i2c_pkg.sv
i2c_master/i2c_bit_timer.sv
i2c_master/i2c_bit_engine.sv
i2c_master/i2c_ctrl_fsm.sv
hdl/i2c_master_top.sv
test/i2c_slave_model.sv
test/tb_i2c_master.sv

/* Makefile */
# Verilator flow for the I2C master

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module i2c_master_top -f vlog.f

sim:
	verilator --binary --timing --top-module tb_i2c_master -f vlog.f
	./obj_dir/Vtb_i2c_master > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Test FAILED" sim.log
	grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
